/* files.f */
common/cnn_pkg.sv
cnn_kernel/cnn_kernel.sv
source/weight_bank.sv
source/channel_sum.sv
source/act_quant.sv
source/cnn_core_top.sv
bench/cnn_core_chk.sv
bench/cnn_core_tb.sv

/* Makefile */
# Verilator build and run for the conv core testbench

SRCS := $(shell grep '\.sv' files.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vcnn_core_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module cnn_core_tb -Mdir obj_dir -o Vcnn_core_tb \
		-f files.f

run: obj_dir/Vcnn_core_tb
	./obj_dir/Vcnn_core_tb | tee sim.log
	grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/cnn_core_tb.sv */
`timescale 1ns/1ps

module cnn_core_tb;

    localparam int CI        = 3;
    localparam int OUT_SHIFT = 8;
    localparam int KK        = cnn_pkg::KK;
    localparam int W_BW      = cnn_pkg::W_BW;
    localparam int IBW       = cnn_pkg::IBW;
    localparam int B_BW      = cnn_pkg::B_BW;
    localparam int O_BW      = cnn_pkg::O_BW;
    localparam int LAT       = cnn_pkg::CORE_LAT;

    logic                          clk = 1'b0;
    logic                          reset_n;
    logic                          i_w_wr;
    logic [1:0]                    i_w_ch;
    logic [KK*W_BW-1:0]            i_w_data;
    logic                          i_b_wr;
    logic signed [B_BW-1:0]        i_b_data;
    logic                          i_in_valid;
    logic [CI*KK*IBW-1:0]          i_in_fmap;
    logic                          o_ot_valid;
    logic [O_BW-1:0]               o_ot_act;

    // reference model state
    logic signed [W_BW-1:0]        m_w [CI][KK];
    logic signed [B_BW-1:0]        m_bias;
    longint                        q_exp[$];
    int unsigned                   q_due[$];
    logic [O_BW-1:0]               last_act;
    int unsigned                   cyc = 0;
    int                            err_val = 0;
    int                            err_misc = 0;
    int                            n_in = 0;
    int                            n_out = 0;

    cnn_core_top #(
        .CI        (CI),
        .OUT_SHIFT (OUT_SHIFT)
    ) uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_w_wr     (i_w_wr),
        .i_w_ch     (i_w_ch),
        .i_w_data   (i_w_data),
        .i_b_wr     (i_b_wr),
        .i_b_data   (i_b_data),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_act   (o_ot_act)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic compare_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            err_val++;
            $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    // relu, truncating shift, unsigned saturation
    function automatic longint quantize(input longint sum);
        longint s;
        if (sum < 0) begin
            return 0;
        end
        s = sum >>> OUT_SHIFT;
        if (s > ((longint'(1) << O_BW) - 1)) begin
            return (longint'(1) << O_BW) - 1;
        end
        return s;
    endfunction

    // to 1 ns after the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // mode 0 random, mode 1 max positive
    task automatic load_weights(input int ch, input int mode);
        logic signed [W_BW-1:0] w;
        for (int t = 0; t < KK; t++) begin
            w = (mode == 0) ? W_BW'($urandom) : W_BW'((1 << (W_BW - 1)) - 1);
            i_w_data[t*W_BW +: W_BW] = w;
            if (ch < CI) begin
                m_w[ch][t] = w;
            end
        end
        i_w_ch = 2'(ch);
        i_w_wr = 1'b1;
        step();
        i_w_wr = 1'b0;
    endtask

    task automatic load_bias(input logic signed [B_BW-1:0] b);
        i_b_data = b;
        m_bias   = b;
        i_b_wr   = 1'b1;
        step();
        i_b_wr   = 1'b0;
    endtask

    // mode 0 random, 1 strongly negative, 2 max positive
    task automatic send_window(input int mode);
        logic signed [IBW-1:0] x;
        longint                sum;
        sum = longint'(m_bias);
        for (int c = 0; c < CI; c++) begin
            for (int t = 0; t < KK; t++) begin
                x = IBW'($urandom);
                if (mode == 1) begin
                    x[IBW-1] = 1'b1;
                    x[IBW-2] = 1'b0;
                end else if (mode == 2) begin
                    x = IBW'((1 << (IBW - 1)) - 1);
                end
                i_in_fmap[(c*KK + t)*IBW +: IBW] = x;
                sum += longint'(x) * longint'(m_w[c][t]);
            end
        end
        i_in_valid = 1'b1;
        q_exp.push_back(quantize(sum));
        q_due.push_back(cyc + LAT);
        n_in++;
        step();
        i_in_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (q_exp.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (q_exp.size() != 0) begin
            err_misc++;
            $display("timeout at %0t: %0d results never came out", $time, q_exp.size());
            q_exp.delete();
            q_due.delete();
        end
        step();
    endtask

    // ==============================
    // output monitor
    // ==============================

    always @(negedge clk) begin : monitor
        longint      exp_act;
        int unsigned due;
        if (!reset_n) begin
            last_act = '0;
            if (o_ot_valid) begin
                err_misc++;
                $display("error at %0t: output valid during reset", $time);
            end
        end else if (o_ot_valid) begin
            if (q_exp.size() == 0) begin
                err_misc++;
                $display("error at %0t: output valid with no window in flight", $time);
            end else begin
                exp_act = q_exp.pop_front();
                due     = q_due.pop_front();
                compare_value("o_ot_act", exp_act, longint'(o_ot_act));
                compare_value("o_ot_valid cycle", longint'(due), longint'(cyc));
            end
            last_act = o_ot_act;
            n_out++;
        end else begin
            compare_value("o_ot_act (held)", longint'(last_act), longint'(o_ot_act));
            if (q_due.size() != 0 && cyc > q_due[0]) begin
                err_misc++;
                $display("error at %0t: expected output missing", $time);
                void'(q_exp.pop_front());
                void'(q_due.pop_front());
            end
        end
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin
        void'($urandom(45));
        reset_n    = 1'b0;
        i_w_wr     = 1'b0;
        i_w_ch     = '0;
        i_w_data   = '0;
        i_b_wr     = 1'b0;
        i_b_data   = '0;
        i_in_valid = 1'b0;
        i_in_fmap  = '0;
        m_bias     = '0;
        for (int c = 0; c < CI; c++) begin
            for (int t = 0; t < KK; t++) begin
                m_w[c][t] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // quiet after reset, then one window
        idle(6);
        for (int c = 0; c < CI; c++) begin
            load_weights(c, 0);
        end
        load_bias(B_BW'($urandom));
        send_window(0);
        wait_drain(4 * LAT);

        // back-to-back stream
        repeat (200) send_window(0);
        wait_drain(4 * LAT);

        // gaps of 1 to 3 cycles
        repeat (100) begin
            send_window(0);
            idle($urandom_range(1, 3));
        end
        wait_drain(4 * LAT);

        // relu floor, then saturation
        for (int c = 0; c < CI; c++) begin
            load_weights(c, 1);
        end
        load_bias(B_BW'($urandom));
        repeat (10) send_window(1);
        wait_drain(4 * LAT);
        load_bias(16'sh7fff);
        repeat (10) send_window(2);
        wait_drain(4 * LAT);

        // reload where the write to index CI must be ignored
        for (int c = 0; c < CI; c++) begin
            load_weights(c, 0);
        end
        load_weights(CI, 1);
        load_bias(B_BW'($urandom));
        repeat (50) send_window(0);
        wait_drain(4 * LAT);

        idle(2);
        compare_value("output count", longint'(n_in), longint'(n_out));
        $display("value errors %0d, other errors %0d, windows %0d, outputs %0d",
                 err_val, err_misc, n_in, n_out);
        if (err_val == 0 && err_misc == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* bench/cnn_core_chk.sv */
`timescale 1ns/1ps

module cnn_core_chk (
    input logic                      clk,
    input logic                      reset_n,
    input logic                      i_in_valid,
    input logic                      o_ot_valid,
    input logic [cnn_pkg::O_BW-1:0]  o_ot_act
);

    // ==============================
    // pipeline timing
    // ==============================

    // each window leaves exactly CORE_LAT edges after it entered
    property p_valid_latency;
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid, cnn_pkg::CORE_LAT);
    endproperty

    a_valid_latency : assert property (p_valid_latency)
        else $error("o_ot_valid does not follow i_in_valid by CORE_LAT cycles");

    // ==============================
    // output data and reset
    // ==============================

    a_act_known : assert property (
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> !$isunknown(o_ot_act)
    ) else $error("o_ot_act has unknown bits while valid");

    a_reset_quiet : assert property (
        @(posedge clk) !reset_n |-> !o_ot_valid
    ) else $error("o_ot_valid high during reset");

endmodule

bind cnn_core_top cnn_core_chk u_chk (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_in_valid (i_in_valid),
    .o_ot_valid (o_ot_valid),
    .o_ot_act   (o_ot_act)
);

/* source/cnn_core_top.sv */
`timescale 1ns/1ps

module cnn_core_top #(
    parameter int CI        = 3,
    parameter int OUT_SHIFT = 8
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      i_w_wr,
    input  logic [((CI > 1) ? $clog2(CI) : 1)-1:0]    i_w_ch,
    input  logic [cnn_pkg::KK*cnn_pkg::W_BW-1:0]      i_w_data,
    input  logic                                      i_b_wr,
    input  logic signed [cnn_pkg::B_BW-1:0]           i_b_data,
    input  logic                                      i_in_valid,
    input  logic [CI*cnn_pkg::KK*cnn_pkg::IBW-1:0]    i_in_fmap,
    output logic                                      o_ot_valid,
    output logic [cnn_pkg::O_BW-1:0]                  o_ot_act
);

    // per-channel slice widths
    localparam int W_ROW = cnn_pkg::KK * cnn_pkg::W_BW;
    localparam int F_ROW = cnn_pkg::KK * cnn_pkg::IBW;
    localparam int S_BW  = cnn_pkg::AK_BW + $clog2(CI);

    logic [CI*W_ROW-1:0]               w_weights;
    logic signed [cnn_pkg::B_BW-1:0]   w_bias;
    logic [CI-1:0]                     k_valid;
    logic [CI*cnn_pkg::AK_BW-1:0]      k_acc;
    logic                              s_valid;
    logic signed [S_BW-1:0]            s_sum;

    // ==============================
    // weights and bias
    // ==============================

    weight_bank #(
        .CI (CI)
    ) u_weight_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_w_wr    (i_w_wr),
        .i_w_ch    (i_w_ch),
        .i_w_data  (i_w_data),
        .i_b_wr    (i_b_wr),
        .i_b_data  (i_b_data),
        .o_weights (w_weights),
        .o_bias    (w_bias)
    );

    // ==============================
    // one kernel per input channel
    // ==============================

    for (genvar c = 0; c < CI; c++) begin : gen_kernel
        cnn_kernel u_kernel (
            .clk             (clk),
            .reset_n         (reset_n),
            .i_cnn_weight    (w_weights[c*W_ROW +: W_ROW]),
            .i_in_valid      (i_in_valid),
            .i_in_fmap       (i_in_fmap[c*F_ROW +: F_ROW]),
            .o_ot_valid      (k_valid[c]),
            .o_ot_kernel_acc (k_acc[c*cnn_pkg::AK_BW +: cnn_pkg::AK_BW])
        );
    end

    // kernels run in lockstep so channel 0 valid stands for all
    channel_sum #(
        .CI (CI)
    ) u_channel_sum (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_valid      (k_valid[0]),
        .i_kernel_acc (k_acc),
        .i_bias       (w_bias),
        .o_valid      (s_valid),
        .o_sum        (s_sum)
    );

    act_quant #(
        .IN_BW     (S_BW),
        .OUT_SHIFT (OUT_SHIFT)
    ) u_act_quant (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (s_valid),
        .i_sum   (s_sum),
        .o_valid (o_ot_valid),
        .o_act   (o_ot_act)
    );

endmodule

/* source/act_quant.sv */
`timescale 1ns/1ps

module act_quant #(
    parameter int IN_BW     = 34,
    parameter int OUT_SHIFT = 8
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_valid,
    input  logic signed [IN_BW-1:0]       i_sum,
    output logic                          o_valid,
    output logic [cnn_pkg::O_BW-1:0]      o_act
);

    // largest unsigned activation at input width
    localparam logic signed [IN_BW-1:0] O_MAX = IN_BW'((1 << cnn_pkg::O_BW) - 1);

    // ==============================
    // relu, shift, saturate
    // ==============================

    logic signed [IN_BW-1:0]    w_shift;
    logic [cnn_pkg::O_BW-1:0]   w_act;

    // truncating arithmetic shift
    assign w_shift = i_sum >>> OUT_SHIFT;

    always_comb begin
        if (i_sum[IN_BW-1]) begin
            w_act = '0;
        end else if (w_shift > O_MAX) begin
            w_act = '1;
        end else begin
            w_act = w_shift[cnn_pkg::O_BW-1:0];
        end
    end

    // output holds while invalid
    logic                     r_valid;
    logic [cnn_pkg::O_BW-1:0] r_act;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
            r_act   <= '0;
        end else begin
            r_valid <= i_valid;
            if (i_valid) begin
                r_act <= w_act;
            end
        end
    end

    assign o_valid = r_valid;
    assign o_act   = r_act;

endmodule

/* source/channel_sum.sv */
`timescale 1ns/1ps

module channel_sum #(
    parameter int CI = 3
) (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          i_valid,
    input  logic signed [CI*cnn_pkg::AK_BW-1:0]           i_kernel_acc,
    input  logic signed [cnn_pkg::B_BW-1:0]               i_bias,
    output logic                                          o_valid,
    output logic signed [cnn_pkg::AK_BW+$clog2(CI)-1:0]   o_sum
);

    // room for CI channel sums plus the bias
    localparam int S_BW = cnn_pkg::AK_BW + $clog2(CI);

    // ==============================
    // sign extension
    // ==============================

    logic signed [cnn_pkg::AK_BW-1:0] w_acc [CI];
    logic signed [S_BW-1:0]           w_ext [CI];
    logic signed [S_BW-1:0]           w_bias_ext;

    for (genvar c = 0; c < CI; c++) begin : gen_ext
        assign w_acc[c] = $signed(i_kernel_acc[c*cnn_pkg::AK_BW +: cnn_pkg::AK_BW]);
        assign w_ext[c] = S_BW'(w_acc[c]);
    end

    assign w_bias_ext = S_BW'(i_bias);

    // ==============================
    // adder tree
    // ==============================

    logic signed [S_BW-1:0] w_total;

    always_comb begin
        w_total = w_bias_ext;
        for (int c = 0; c < CI; c++) begin
            w_total = w_total + w_ext[c];
        end
    end

    // total and valid registered together
    logic                   r_valid;
    logic signed [S_BW-1:0] r_sum;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_sum <= '0;
        end else if (i_valid) begin
            r_sum <= w_total;
        end
    end

    assign o_valid = r_valid;
    assign o_sum   = r_sum;

endmodule

/* source/weight_bank.sv */
`timescale 1ns/1ps

module weight_bank #(
    parameter int CI = 3
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       i_w_wr,
    input  logic [((CI > 1) ? $clog2(CI) : 1)-1:0]     i_w_ch,
    input  logic [cnn_pkg::KK*cnn_pkg::W_BW-1:0]       i_w_data,
    input  logic                                       i_b_wr,
    input  logic signed [cnn_pkg::B_BW-1:0]            i_b_data,
    output logic [CI*cnn_pkg::KK*cnn_pkg::W_BW-1:0]    o_weights,
    output logic signed [cnn_pkg::B_BW-1:0]            o_bias
);

    localparam int ROW_BW = cnn_pkg::KK * cnn_pkg::W_BW;

    // ==============================
    // weight rows
    // ==============================

    logic [CI-1:0][ROW_BW-1:0] r_weights;
    logic [CI-1:0]             w_row_we;

    // indices of CI and above match no row
    for (genvar c = 0; c < CI; c++) begin : gen_row
        assign w_row_we[c] = i_w_wr && (int'(i_w_ch) == c);

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                r_weights[c] <= '0;
            end else if (w_row_we[c]) begin
                r_weights[c] <= i_w_data;
            end
        end
    end

    // ==============================
    // bias
    // ==============================

    logic signed [cnn_pkg::B_BW-1:0] r_bias;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_bias <= '0;
        end else if (i_b_wr) begin
            r_bias <= i_b_data;
        end
    end

    // channel c in slice c
    assign o_weights = r_weights;
    assign o_bias    = r_bias;

endmodule

/* cnn_kernel/cnn_kernel.sv */
`timescale 1ns/1ps

module cnn_kernel (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic signed [cnn_pkg::KK*cnn_pkg::W_BW-1:0] i_cnn_weight,
    input  logic                                        i_in_valid,
    input  logic signed [cnn_pkg::KK*cnn_pkg::IBW-1:0]  i_in_fmap,
    output logic                                        o_ot_valid,
    output logic signed [cnn_pkg::AK_BW-1:0]            o_ot_kernel_acc
);

    localparam int LAT = cnn_pkg::KERNEL_LAT;

    // ==============================
    // valid pipe
    // ==============================

    logic [LAT-1:0] r_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[LAT-2:0], i_in_valid};
        end
    end

    // ==============================
    // products of fmap and weight
    // ==============================

    logic signed [cnn_pkg::M_BW-1:0] w_mul [cnn_pkg::KK];
    logic signed [cnn_pkg::M_BW-1:0] r_mul [cnn_pkg::KK];

    for (genvar t = 0; t < cnn_pkg::KK; t++) begin : gen_mul
        assign w_mul[t] = $signed(i_in_fmap[t*cnn_pkg::IBW +: cnn_pkg::IBW])
                        * $signed(i_cnn_weight[t*cnn_pkg::W_BW +: cnn_pkg::W_BW]);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int t = 0; t < cnn_pkg::KK; t++) begin
                r_mul[t] <= '0;
            end
        end else if (i_in_valid) begin
            for (int t = 0; t < cnn_pkg::KK; t++) begin
                r_mul[t] <= w_mul[t];
            end
        end
    end

    // ==============================
    // accumulate 25 products
    // ==============================

    // one partial sum per kernel row, then the row total
    logic signed [cnn_pkg::AK_BW-1:0] w_row [cnn_pkg::KY];
    logic signed [cnn_pkg::AK_BW-1:0] w_acc;
    logic signed [cnn_pkg::AK_BW-1:0] r_acc;

    always_comb begin
        w_acc = '0;
        for (int r = 0; r < cnn_pkg::KY; r++) begin
            w_row[r] = '0;
            for (int k = 0; k < cnn_pkg::KX; k++) begin
                w_row[r] = w_row[r] + r_mul[r*cnn_pkg::KX + k];
            end
            w_acc = w_acc + w_row[r];
        end
    end

    // enabled by the products' valid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_acc <= '0;
        end else if (r_valid[LAT-2]) begin
            r_acc <= w_acc;
        end
    end

    assign o_ot_valid      = r_valid[LAT-1];
    assign o_ot_kernel_acc = r_acc;

endmodule

/* common/cnn_pkg.sv */
package cnn_pkg;

    // ==============================
    // kernel geometry
    // ==============================

    // 5x5 window per input channel
    localparam int KX = 5;
    localparam int KY = 5;

    // taps per channel with index row * KX + col
    localparam int KK = KX * KY;

    // ==============================
    // data widths
    // ==============================

    // signed weight
    localparam int W_BW = 7;

    // signed feature-map sample
    localparam int IBW = 20;

    // signed product of IBW and W_BW bits
    localparam int M_BW = IBW + W_BW;

    // per-channel kernel sum with 5 bits of growth over 25 terms
    localparam int AK_BW = M_BW + 5;

    // signed bias
    localparam int B_BW = 16;

    // unsigned activation
    localparam int O_BW = 16;

    // ==============================
    // pipeline timing
    // ==============================

    // product stage + sum stage
    localparam int KERNEL_LAT = 2;

    // kernel, channel sum, quantizer
    localparam int CORE_LAT = KERNEL_LAT + 2;

endpackage
